//--- source/uart_bridge_macros.svh
// uart bridge constants
`ifndef UART_BRIDGE_MACROS_SVH
`define UART_BRIDGE_MACROS_SVH

// serial bit period in clock cycles
`define UART_BRIDGE_CLKS_PER_BIT 8

// frame start characters and hex digit bounds
`define CHAR_L 8'h4C
`define CHAR_S 8'h53
`define CHAR_0 8'h30
`define CHAR_9 8'h39
`define CHAR_A 8'h41
`define CHAR_F 8'h46

// command codes, low 16 bits of the command word
`define CMD_WRITE 16'h0001
`define CMD_READ 16'h0002

// response status words
`define STATUS_OK 32'h0000_0000
`define STATUS_BAD_CMD 32'h0000_0001
`define STATUS_BUS_ERR 32'h0000_0002

`endif

//--- source/uart_bridge_pkg.sv
// uart bridge shared types
package uart_bridge_pkg;

	// serial character, hex digit, bus word
	typedef logic [7:0] byte_t;
	typedef logic [3:0] nibble_t;
	typedef logic [31:0] word_t;

	// decoded operation
	typedef enum logic [1:0] {op_write, op_read, op_bad} op_t;

	// fsm encodings
	typedef enum logic [2:0] {
		dec_wait_l, dec_command, dec_address, dec_data, dec_hold
	} decode_state_t;
	typedef enum logic [1:0] {bus_idle, bus_cycle, bus_done} bus_state_t;
	typedef enum logic {enc_idle, enc_send} encode_state_t;

	// decoder to executor
	typedef struct packed {
		op_t op;
		word_t address;
		word_t data;
	} bus_request_t;

	// executor to encoder
	typedef struct packed {
		word_t status;
		word_t address;
		word_t data;
	} bus_result_t;

	// wishbone master side
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		word_t adr;
		word_t dat_w;
	} wb_master_t;

	// wishbone slave side
	typedef struct packed {
		logic ack;
		logic err;
		word_t dat_r;
	} wb_slave_t;

endpackage

//--- source/uart_phy.sv
// uart 8n1 phy
`timescale 1ns/1ps
`include "uart_bridge_macros.svh"

module uart_phy (
	input logic clk,
	input logic rst,
	input logic rx,
	output logic tx,
	input logic tx_start,
	input uart_bridge_pkg::byte_t tx_byte,
	output logic tx_busy,
	output logic rx_valid,
	output uart_bridge_pkg::byte_t rx_byte
);
	import uart_bridge_pkg::*;

	localparam int CLKS = `UART_BRIDGE_CLKS_PER_BIT;
	localparam int CNT_W = $clog2(CLKS + 1);

	// rx synchronizer
	logic rx_meta;
	logic rx_sync;
	// receiver state
	logic rx_active;
	logic [CNT_W-1:0] rx_clk_cnt;
	logic [3:0] rx_bit_cnt;
	byte_t rx_shift;
	// transmitter state
	logic [CNT_W-1:0] tx_clk_cnt;
	logic [3:0] tx_bit_cnt;
	logic [9:0] tx_shift;

	always_ff @(posedge clk) begin
		rx_meta <= rx;
		rx_sync <= rx_meta;
	end

	// bit 0 is the start bit, sampled after half a period
	// bits 1-8 data lsb first, bit 9 stop
	always_ff @(posedge clk) begin
		if (rst) begin
			rx_active <= 1'b0;
			rx_valid <= 1'b0;
			rx_clk_cnt <= '0;
			rx_bit_cnt <= '0;
		end else begin
			rx_valid <= 1'b0;
			if (!rx_active) begin
				// falling edge on the line
				if (!rx_sync) begin
					rx_active <= 1'b1;
					rx_clk_cnt <= '0;
					rx_bit_cnt <= '0;
				end
			end else if ((rx_bit_cnt == 4'd0 && rx_clk_cnt == CNT_W'(CLKS / 2 - 1)) ||
					(rx_bit_cnt != 4'd0 && rx_clk_cnt == CNT_W'(CLKS - 1))) begin
				rx_clk_cnt <= '0;
				rx_bit_cnt <= rx_bit_cnt + 4'd1;
				if (rx_bit_cnt == 4'd0) begin
					// glitch, not a real start bit
					if (rx_sync)
						rx_active <= 1'b0;
				end else if (rx_bit_cnt == 4'd9) begin
					rx_active <= 1'b0;
					// bad stop bit just drops the byte
					rx_valid <= rx_sync;
				end else begin
					rx_shift <= {rx_sync, rx_shift[7:1]};
				end
			end else begin
				rx_clk_cnt <= rx_clk_cnt + CNT_W'(1);
			end
		end
	end

	// shift register keeps the byte until the next frame
	assign rx_byte = rx_shift;

	// tx_shift[0] is the bit on the line
	always_ff @(posedge clk) begin
		if (rst) begin
			tx <= 1'b1;
			tx_busy <= 1'b0;
			tx_clk_cnt <= '0;
			tx_bit_cnt <= '0;
			tx_shift <= '1;
		end else if (!tx_busy) begin
			if (tx_start) begin
				tx_shift <= {1'b1, tx_byte, 1'b0};
				tx <= 1'b0;
				tx_busy <= 1'b1;
				tx_clk_cnt <= '0;
				tx_bit_cnt <= '0;
			end
		end else if (tx_clk_cnt == CNT_W'(CLKS - 1)) begin
			tx_clk_cnt <= '0;
			if (tx_bit_cnt == 4'd9) begin
				// end of stop bit
				tx_busy <= 1'b0;
			end else begin
				tx_bit_cnt <= tx_bit_cnt + 4'd1;
				tx_shift <= {1'b1, tx_shift[9:1]};
				tx <= tx_shift[1];
			end
		end else begin
			tx_clk_cnt <= tx_clk_cnt + CNT_W'(1);
		end
	end

	// encoder must wait for the phy
	a_no_start_while_busy: assert property (@(posedge clk) disable iff (rst)
		tx_start |-> !tx_busy);

endmodule

//--- source/command_decoder.sv
// ascii hex command decoder
`timescale 1ns/1ps
`include "uart_bridge_macros.svh"

module command_decoder (
	input logic clk,
	input logic rst,
	input logic rx_valid,
	input uart_bridge_pkg::byte_t rx_byte,
	output uart_bridge_pkg::bus_request_t request,
	output logic request_valid,
	input logic request_ready
);
	import uart_bridge_pkg::*;

	decode_state_t state;
	logic [2:0] nibble_cnt;
	word_t command;
	logic hex_ok;
	logic take;
	nibble_t digit;

	function automatic logic is_hex(input byte_t c);
		return (c >= `CHAR_0 && c <= `CHAR_9) || (c >= `CHAR_A && c <= `CHAR_F);
	endfunction

	function automatic nibble_t to_nibble(input byte_t c);
		byte_t v;
		if (c >= `CHAR_A)
			v = c - `CHAR_A + 8'd10;
		else
			v = c - `CHAR_0;
		return v[3:0];
	endfunction

	assign hex_ok = is_hex(rx_byte);
	assign digit = to_nibble(rx_byte);
	// a valid digit while one of the word fields is being parsed
	assign take = rx_valid && hex_ok &&
		(state == dec_command || state == dec_address || state == dec_data);
	assign request_valid = (state == dec_hold);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= dec_wait_l;
			nibble_cnt <= '0;
		end else begin
			case (state)
				dec_wait_l: begin
					nibble_cnt <= '0;
					if (rx_valid && rx_byte == `CHAR_L)
						state <= dec_command;
				end
				dec_command, dec_address, dec_data: begin
					if (rx_valid && !hex_ok) begin
						// broken frame, resync on next L
						state <= dec_wait_l;
					end else if (rx_valid) begin
						// counter wraps to 0 after the 8th digit
						nibble_cnt <= nibble_cnt + 3'd1;
						if (nibble_cnt == 3'd7) begin
							if (state == dec_command)
								state <= dec_address;
							else if (state == dec_address)
								state <= dec_data;
							else
								state <= dec_hold;
						end
					end
				end
				// rx characters ignored here
				dec_hold: if (request_ready) state <= dec_wait_l;
				default: state <= dec_wait_l;
			endcase
		end
	end

	// word fields shift in msb first
	always_ff @(posedge clk) begin
		if (take) begin
			case (state)
				dec_command: command <= {command[27:0], digit};
				dec_address: request.address <= {request.address[27:0], digit};
				default: request.data <= {request.data[27:0], digit};
			endcase
		end
		// classify once the last digit arrives
		if (take && state == dec_data && nibble_cnt == 3'd7) begin
			case (command[15:0])
				`CMD_WRITE: request.op <= op_write;
				`CMD_READ: request.op <= op_read;
				default: request.op <= op_bad;
			endcase
		end
	end

endmodule

//--- source/bus_executor.sv
// wishbone classic master
`timescale 1ns/1ps
`include "uart_bridge_macros.svh"

module bus_executor (
	input logic clk,
	input logic rst,
	input uart_bridge_pkg::bus_request_t request,
	input logic request_valid,
	output logic request_ready,
	output uart_bridge_pkg::wb_master_t wb_out,
	input uart_bridge_pkg::wb_slave_t wb_in,
	output uart_bridge_pkg::bus_result_t result,
	output logic result_valid,
	input logic result_ready
);
	import uart_bridge_pkg::*;

	bus_state_t state;
	bus_request_t req_reg;
	logic accept;
	logic bus_end;

	assign request_ready = (state == bus_idle);
	assign result_valid = (state == bus_done);
	assign accept = request_valid && request_ready;
	// first edge with ack or err closes the cycle
	assign bus_end = (state == bus_cycle) && (wb_in.ack || wb_in.err);

	always_comb begin
		wb_out.cyc = (state == bus_cycle);
		wb_out.stb = (state == bus_cycle);
		wb_out.we = (req_reg.op == op_write);
		wb_out.adr = req_reg.address;
		wb_out.dat_w = req_reg.data;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= bus_idle;
		end else begin
			case (state)
				// bad command never touches the bus
				bus_idle: if (accept) state <= (request.op == op_bad) ? bus_done : bus_cycle;
				bus_cycle: if (bus_end) state <= bus_done;
				// hold result until encoder takes it
				bus_done: if (result_ready) state <= bus_idle;
				default: state <= bus_idle;
			endcase
		end
	end

	// status preset for bad command, replaced when the bus answers
	always_ff @(posedge clk) begin
		if (accept) begin
			req_reg <= request;
			result.status <= `STATUS_BAD_CMD;
			result.address <= request.address;
			result.data <= request.data;
		end else if (bus_end) begin
			result.status <= wb_in.ack ? `STATUS_OK : `STATUS_BUS_ERR;
			if (wb_in.ack && req_reg.op == op_read)
				result.data <= wb_in.dat_r;
		end
	end

	// slave answers only inside an open cycle
	a_answer_in_cycle: assert property (@(posedge clk) disable iff (rst)
		(wb_in.ack || wb_in.err) |-> wb_out.stb);
	a_adr_stable: assert property (@(posedge clk) disable iff (rst)
		wb_out.stb |=> !wb_out.stb || $stable(wb_out.adr));

endmodule

//--- source/response_encoder.sv
// ascii hex response encoder
`timescale 1ns/1ps
`include "uart_bridge_macros.svh"

module response_encoder (
	input logic clk,
	input logic rst,
	input uart_bridge_pkg::bus_result_t result,
	input logic result_valid,
	output logic result_ready,
	output logic tx_start,
	output uart_bridge_pkg::byte_t tx_byte,
	input logic tx_busy
);
	import uart_bridge_pkg::*;

	encode_state_t state;
	logic wait_flag;
	logic send_slot;
	logic accept;
	logic emit;
	logic [4:0] nibble_cnt;
	word_t out_status;
	word_t out_address;
	word_t out_data;

	function automatic byte_t hex_char(input nibble_t nib);
		if (nib < 4'd10)
			return `CHAR_0 + {4'h0, nib};
		else
			return `CHAR_A + {4'h0, nib} - 8'd10;
	endfunction

	// phy free and no start still in flight
	assign send_slot = !wait_flag && !tx_busy;
	assign result_ready = (state == enc_idle) && send_slot;
	assign accept = result_valid && result_ready;
	assign emit = (state == enc_send) && send_slot;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= enc_idle;
			wait_flag <= 1'b0;
			tx_start <= 1'b0;
			nibble_cnt <= '0;
		end else begin
			tx_start <= 1'b0;
			// phy has picked up the byte
			if (tx_busy)
				wait_flag <= 1'b0;
			if (accept) begin
				state <= enc_send;
				nibble_cnt <= '0;
				tx_start <= 1'b1;
				wait_flag <= 1'b1;
			end else if (emit) begin
				tx_start <= 1'b1;
				wait_flag <= 1'b1;
				nibble_cnt <= nibble_cnt + 5'd1;
				// 24th nibble, frame complete
				if (nibble_cnt == 5'd23)
					state <= enc_idle;
			end
		end
	end

	// S first, then status, address, data top nibble first
	always_ff @(posedge clk) begin
		if (accept) begin
			tx_byte <= `CHAR_S;
			{out_status, out_address, out_data} <= {result.status, result.address, result.data};
		end else if (emit) begin
			tx_byte <= hex_char(out_status[31:28]);
			{out_status, out_address, out_data} <= {out_status[27:0], out_address, out_data, 4'h0};
		end
	end

endmodule

//--- source/uart_bridge.sv
// uart to wishbone bridge top
`timescale 1ns/1ps

module uart_bridge (
	input logic clk,
	input logic rst,
	input logic rx,
	output logic tx,
	output uart_bridge_pkg::wb_master_t wb_out,
	input uart_bridge_pkg::wb_slave_t wb_in
);
	import uart_bridge_pkg::*;

	// phy byte streams
	logic rx_valid;
	byte_t rx_byte;
	logic tx_start;
	byte_t tx_byte;
	logic tx_busy;
	// request channel
	bus_request_t request;
	logic request_valid;
	logic request_ready;
	// result channel
	bus_result_t result;
	logic result_valid;
	logic result_ready;

	uart_phy uart_phy_inst (
		.clk(clk), .rst(rst), .rx(rx), .tx(tx),
		.tx_start(tx_start), .tx_byte(tx_byte), .tx_busy(tx_busy),
		.rx_valid(rx_valid), .rx_byte(rx_byte)
	);

	command_decoder command_decoder_inst (
		.clk(clk), .rst(rst), .rx_valid(rx_valid), .rx_byte(rx_byte),
		.request(request), .request_valid(request_valid), .request_ready(request_ready)
	);

	bus_executor bus_executor_inst (
		.clk(clk), .rst(rst), .request(request), .request_valid(request_valid),
		.request_ready(request_ready), .wb_out(wb_out), .wb_in(wb_in),
		.result(result), .result_valid(result_valid), .result_ready(result_ready)
	);

	response_encoder response_encoder_inst (
		.clk(clk), .rst(rst), .result(result), .result_valid(result_valid),
		.result_ready(result_ready), .tx_start(tx_start), .tx_byte(tx_byte),
		.tx_busy(tx_busy)
	);

endmodule

//--- bench/clock_gen.sv
// testbench clock source
`timescale 1ns/1ps

module clock_gen (
	output logic clk
);
	// 4 ns period
	localparam int HALF_PERIOD = 2;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

endmodule

//--- bench/uart_bridge_tb.sv
// uart bridge testbench
`timescale 1ns/1ps
`include "uart_bridge_macros.svh"

module uart_bridge_tb;
	import uart_bridge_pkg::*;

	localparam int CLKS = `UART_BRIDGE_CLKS_PER_BIT;
	localparam int MAX_LINES = 32;
	// frame time plus bus latency, in clocks
	localparam int FIRST_LIMIT = 40 * 10 * CLKS;
	// gap between response characters
	localparam int NEXT_LIMIT = 4 * 10 * CLKS;
	// status markers in the data file
	localparam word_t CUT_FRAME = 32'h0000_FFFF;
	localparam word_t END_OF_LIST = 32'hFFFF_FFFF;
	// digit n sits at bits 8*(15-n)
	localparam logic [127:0] HEX_DIGITS = "0123456789ABCDEF";

	logic clk;
	logic rst;
	logic rx;
	logic tx;
	wb_master_t wb_out;
	wb_slave_t wb_in;

	// five words per transaction line
	word_t tdata [0:5*MAX_LINES-1];
	// slave memory and bus monitor
	word_t mem [0:15];
	int seed;
	int cycle_count;
	logic last_we;
	word_t last_adr;
	word_t last_dat;

	clock_gen clock_gen_inst (.clk(clk));

	uart_bridge uart_bridge_inst (
		.clk(clk), .rst(rst), .rx(rx), .tx(tx), .wb_out(wb_out), .wb_in(wb_in)
	);

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped on the first failure");
	endtask

	task automatic check_word(input string what, input word_t got, input word_t exp);
		assert (got == exp) else
			stop_with_failure($sformatf("[ERROR] %0t ns: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	function automatic byte_t hex_char(input nibble_t n);
		return HEX_DIGITS[8*(15-n) +: 8];
	endfunction

	// -1 for anything outside 0-9 and A-F
	function automatic int hex_index(input byte_t c);
		for (int i = 0; i < 16; i++)
			if (hex_char(nibble_t'(i)) == c)
				return i;
		return -1;
	endfunction

	// one bit period, changed 1 ns after the edge
	task automatic drive_bit(input logic value);
		@(posedge clk);
		#1 rx = value;
		repeat (CLKS - 1) @(posedge clk);
	endtask

	task automatic send_char(input byte_t c);
		drive_bit(1'b0);
		for (int i = 0; i < 8; i++)
			drive_bit(c[i]);
		drive_bit(1'b1);
	endtask

	task automatic transmit_frame(input word_t cmd, input word_t addr, input word_t data,
			input logic cut);
		logic [95:0] fields;
		fields = {cmd, addr, data};
		send_char(`CHAR_L);
		for (int i = 0; i < 24; i++) begin
			// G in place of the 21st digit breaks the frame
			if (cut && i == 20) begin
				send_char("G");
				return;
			end
			send_char(hex_char(fields[95:92]));
			fields = fields << 4;
		end
	endtask

	// tx sampled on falling edges, mid bit
	task automatic sample_char(input int limit, output logic got, output byte_t b);
		int n;
		got = 1'b0;
		b = '0;
		n = 0;
		@(negedge clk);
		while (tx !== 1'b0 && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (tx !== 1'b0)
			return;
		repeat (CLKS / 2) @(negedge clk);
		assert (tx === 1'b0) else stop_with_failure("start bit on tx ended too early");
		for (int i = 0; i < 8; i++) begin
			repeat (CLKS) @(negedge clk);
			b[i] = tx;
		end
		repeat (CLKS) @(negedge clk);
		assert (tx === 1'b1) else stop_with_failure("stop bit missing on tx");
		got = 1'b1;
	endtask

	task automatic collect_response(output logic got, output logic [95:0] fields);
		byte_t c;
		logic ok;
		int idx;
		fields = '0;
		sample_char(FIRST_LIMIT, got, c);
		if (!got)
			return;
		check_word("first response character", {24'h0, c}, {24'h0, `CHAR_S});
		for (int n = 0; n < 24; n++) begin
			sample_char(NEXT_LIMIT, ok, c);
			assert (ok) else stop_with_failure("timeout waiting for a response character");
			idx = hex_index(c);
			assert (idx >= 0) else
				stop_with_failure($sformatf("[ERROR] %0t ns: response character %h is not hex",
					$time, c));
			fields = {fields[91:0], idx[3:0]};
		end
		// exactly 25 characters
		sample_char(NEXT_LIMIT, ok, c);
		assert (!ok) else
			stop_with_failure($sformatf("[ERROR] %0t ns: extra character %h after response",
				$time, c));
	endtask

	// slave answers 0 to 3 cycles after cyc, err when adr bit 31 is set
	initial begin : wishbone_model
		int delay;
		logic pending;
		seed = 32'h97bc;
		wb_in = '0;
		pending = 1'b0;
		delay = 0;
		cycle_count = 0;
		for (int i = 0; i < 16; i++)
			mem[i] = 32'h5EED_0000 | i;
		forever begin
			@(posedge clk);
			#1;
			if (wb_in.ack || wb_in.err) begin
				// master sampled the answer on this edge
				wb_in = '0;
				pending = 1'b0;
			end else if (wb_out.cyc && wb_out.stb) begin
				if (!pending) begin
					pending = 1'b1;
					cycle_count++;
					delay = $unsigned($random(seed)) % 4;
				end
				if (delay == 0) begin
					last_we = wb_out.we;
					last_adr = wb_out.adr;
					last_dat = wb_out.dat_w;
					if (wb_out.adr[31]) begin
						wb_in.err = 1'b1;
						// junk that must not reach the response
						wb_in.dat_r = ~wb_out.dat_w;
					end else begin
						if (wb_out.we)
							mem[wb_out.adr[5:2]] = wb_out.dat_w;
						wb_in.ack = 1'b1;
						wb_in.dat_r = mem[wb_out.adr[5:2]];
					end
				end else begin
					delay--;
				end
			end
		end
	end

	initial begin : run
		int line;
		int cycles_before;
		word_t cmd;
		word_t addr;
		word_t wdata;
		word_t exp_status;
		word_t exp_data;
		logic got;
		logic [95:0] resp;
		rx = 1'b1;
		rst = 1'b1;
		$readmemh("bench/uart_bridge_testdata.txt", tdata);
		repeat (8) @(posedge clk);
		#1 rst = 1'b0;
		line = 0;
		while (line < MAX_LINES && tdata[5*line+3] != END_OF_LIST) begin
			cmd = tdata[5*line];
			addr = tdata[5*line+1];
			wdata = tdata[5*line+2];
			exp_status = tdata[5*line+3];
			exp_data = tdata[5*line+4];
			cycles_before = cycle_count;
			// response may start before the last stop bit ends
			fork
				transmit_frame(cmd, addr, wdata, exp_status == CUT_FRAME);
				collect_response(got, resp);
			join
			if (exp_status == CUT_FRAME) begin
				assert (!got) else stop_with_failure("a broken frame was answered");
				check_word("bus cycles after broken frame", cycle_count, cycles_before);
			end else begin
				assert (got) else stop_with_failure("timeout waiting for a response");
				check_word("response status", resp[95:64], exp_status);
				check_word("response address", resp[63:32], addr);
				check_word("response data", resp[31:0], exp_data);
				if (cmd[15:0] != `CMD_WRITE && cmd[15:0] != `CMD_READ) begin
					// bad command never raises cyc
					check_word("bus cycles", cycle_count, cycles_before);
				end else begin
					check_word("bus cycles", cycle_count, cycles_before + 1);
					check_word("bus address", last_adr, addr);
					check_word("bus we", {31'h0, last_we}, {31'h0, cmd[15:0] == `CMD_WRITE});
					if (last_we)
						check_word("bus write data", last_dat, wdata);
				end
			end
			line++;
		end
		// list must stop on its end line
		assert (line < MAX_LINES && tdata[5*line+3] === END_OF_LIST) else
			stop_with_failure("test data has no end line");
		$display(">>> PASS");
		$finish;
	end

endmodule

//--- uart_bridge.f
+incdir+source
source/uart_bridge_pkg.sv
source/uart_phy.sv
source/command_decoder.sv
source/bus_executor.sv
source/response_encoder.sv
source/uart_bridge.sv
bench/clock_gen.sv
bench/uart_bridge_tb.sv

//--- Makefile
# Verilator build and run of the uart bridge testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 -f uart_bridge.f \
		--top-module uart_bridge_tb -o uart_bridge_sim
	./obj_dir/uart_bridge_sim

clean:
	rm -rf obj_dir

//--- bench/uart_bridge_testdata.txt
// command address write_data expected_status expected_response_data
// status 0000FFFF is a frame cut by a bad character, a line of all F ends the list
00000001 00000000 11223344 00000000 11223344
00000001 00000004 CAFEF00D 00000000 CAFEF00D
00000001 0000003C 89ABCDEF 00000000 89ABCDEF
00000002 00000000 00000000 00000000 11223344
00000002 00000004 12345678 00000000 CAFEF00D
00000002 0000003C 00000000 00000000 89ABCDEF
00000002 00000040 00000000 00000000 11223344
00000001 80000010 55AA55AA 00000002 55AA55AA
00000002 80000000 DEADBEEF 00000002 DEADBEEF
00000002 00000010 00000000 00000000 5EED0004
00000003 00000008 01020304 00000001 01020304
12340000 00000020 A5A5A5A5 00000001 A5A5A5A5
FFFF0001 00000008 0BADC0DE 00000000 0BADC0DE
00000001 0000000C 77777777 0000FFFF 00000000
00000002 0000000C 00000000 00000000 5EED0003
00000002 00000008 00000000 00000000 0BADC0DE
00000001 00000024 00000000 00000000 00000000
00000002 00000024 FFFFFFFF 00000000 00000000
00000001 00001238 0F1E2D3C 00000000 0F1E2D3C
00000002 00000038 00000000 00000000 0F1E2D3C
0000FFFF 00000000 13579BDF 00000001 13579BDF
00000001 00000014 9ABCDEF0 0000FFFF 00000000
00000002 00000014 00000000 00000000 5EED0005
00000002 8000003C 2468ACE0 00000002 2468ACE0
00000002 0000003C 00000000 00000000 89ABCDEF
FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF FFFFFFFF
